// File: useless_box_top.f
+incdir+design
+incdir+tb
design/box_pkg.sv
design/interval_timer.sv
design/mode_picker.sv
design/phase_sequencer.sv
design/motor_driver.sv
design/useless_box_top.sv
tb/tb_useless_box.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_useless_box \
    -f useless_box_top.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_useless_box > sim.log 2>&1 \
    || { echo "simulation did not run, see sim.log"; exit 1; }

grep -q -F '*** PASSED ***' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam int LID_PULSE  = 3;
localparam int HAND_PULSE = 6;
localparam int MAX_TRACE  = 64;

// act description as a phase list, then expanded to one entry per cycle
box_pkg::phase_e     plan_ph[$];
int                  plan_dur[$];
box_pkg::phase_e     trace_ph[$];
box_pkg::motor_cmd_t trace_mot [0:MAX_TRACE-1];

task automatic tick();
    @(posedge clk);
    #5;
endtask

task automatic check_outputs(input string name, input box_pkg::phase_e exp_phase,
                             input logic exp_busy, input box_pkg::mode_t exp_mode,
                             input box_pkg::motor_cmd_t exp_motor);
    assert (phase == exp_phase) else begin
        $display("ERR %s cycle %0d phase expected %s actual %s",
                 name, cycle_cnt, exp_phase.name(), phase.name());
        err_phase++;
    end
    assert (busy == exp_busy) else begin
        $display("ERR %s cycle %0d busy expected %b actual %b", name, cycle_cnt, exp_busy, busy);
        err_busy++;
    end
    assert (mode == exp_mode) else begin
        $display("ERR %s cycle %0d mode expected %0d actual %0d", name, cycle_cnt, exp_mode, mode);
        err_mode++;
    end
    assert (motor == exp_motor) else begin
        $display("ERR %s cycle %0d motor expected %b actual %b",
                 name, cycle_cnt, exp_motor, motor);
        err_motor++;
    end
endtask

task automatic check_idle(input string name);
    check_outputs(name, box_pkg::IDLE, 1'b0, last_mode, '0);
endtask

function automatic box_pkg::motor_cmd_t motor_for(input box_pkg::phase_e ph);
    box_pkg::motor_cmd_t m;
    m = '0;
    case (ph)
        box_pkg::OPEN_LID: m.lid_en = 1'b1;
        box_pkg::CLOSE_LID: begin
            m.lid_en  = 1'b1;
            m.lid_dir = 1'b1;
        end
        box_pkg::HAND_OUT: m.hand_en = 1'b1;
        box_pkg::HAND_IN: begin
            m.hand_en  = 1'b1;
            m.hand_dir = 1'b1;
        end
        default: m = '0;
    endcase
    return m;
endfunction

function automatic void push_phase(input box_pkg::phase_e ph, input int dur);
    plan_ph.push_back(ph);
    plan_dur.push_back(dur);
endfunction

function automatic void build_act(input int act);
    int i;
    int j;
    int start;
    int pulse;
    plan_ph.delete();
    plan_dur.delete();
    trace_ph.delete();
    for (i = 0; i < MAX_TRACE; i++) trace_mot[i] = '0;
    if (act == 2) begin
        for (i = 0; i < 3; i++) begin  // empty peeks
            push_phase(box_pkg::OPEN_LID, 3);
            push_phase(box_pkg::CLOSE_LID, 3);
        end
    end
    case (act)
        1: begin
            push_phase(box_pkg::OPEN_LID, 15);
            push_phase(box_pkg::HAND_OUT, 10);
            push_phase(box_pkg::HAND_IN, 10);
        end
        3: begin
            push_phase(box_pkg::OPEN_LID, 3);
            for (i = 0; i < 4; i++) begin
                push_phase(box_pkg::HAND_OUT, 6);
                push_phase(box_pkg::HAND_IN, 6);
            end
        end
        default: begin
            push_phase(box_pkg::OPEN_LID, 3);
            push_phase(box_pkg::HAND_OUT, 6);
            push_phase(box_pkg::HAND_IN, 6);
        end
    endcase
    push_phase(box_pkg::CLOSE_LID, 3);
    for (i = 0; i < plan_ph.size(); i++) begin
        start = trace_ph.size();
        pulse = (plan_ph[i] == box_pkg::OPEN_LID || plan_ph[i] == box_pkg::CLOSE_LID)
                ? LID_PULSE : HAND_PULSE;
        for (j = 0; j < plan_dur[i]; j++) trace_ph.push_back(plan_ph[i]);
        // motor output is registered behind the phase entry
        for (j = 1; j <= pulse; j++) trace_mot[start + j] = motor_for(plan_ph[i]);
    end
endfunction

// one-cycle press in the cycle whose counter value selects the act
task automatic press_for_act(input string name, input int act);
    tick();
    check_idle(name);
    while ((cycle_cnt % 4) != act) begin
        tick();
        check_idle(name);
    end
    switch_in = 1'b1;
    tick();
    switch_in = 1'b0;
    check_idle(name);
endtask

// follows the act cycle by cycle from the first OPEN_LID cycle to the IDLE after it
task automatic run_trace(input string name, input int act, input int poke_at,
                         input bit hold_tail, output int next_mode);
    int total;
    int o;
    build_act(act);
    total     = trace_ph.size();
    next_mode = 0;
    for (o = 0; o < total; o++) begin
        tick();
        switch_in = (o == poke_at) || (hold_tail && (o >= total - 2));
        if (o == total - 1) next_mode = cycle_cnt % 4;  // sampled into the restart
        check_outputs(name, trace_ph[o], 1'b1, box_pkg::mode_t'(act), trace_mot[o]);
    end
    tick();
    switch_in = hold_tail;
    check_outputs(name, box_pkg::IDLE, 1'b0, box_pkg::mode_t'(act), trace_mot[total]);
    last_mode = box_pkg::mode_t'(act);
endtask

task automatic check_reset_state();
    check_idle("reset");
    repeat (8) begin
        tick();
        check_idle("reset");
    end
endtask

task automatic play_plain_act();
    int unused_mode;
    press_for_act("plain", 0);
    run_trace("plain", 0, -1, 1'b0, unused_mode);
endtask

task automatic play_slow_act();
    int unused_mode;
    press_for_act("slow", 1);
    run_trace("slow", 1, -1, 1'b0, unused_mode);
endtask

task automatic play_peek_act();
    int unused_mode;
    press_for_act("peek", 2);
    run_trace("peek", 2, -1, 1'b0, unused_mode);
endtask

task automatic play_repeat_act();
    int unused_mode;
    press_for_act("repeat", 3);
    run_trace("repeat", 3, -1, 1'b0, unused_mode);
endtask

task automatic check_busy_and_hold();
    int next_mode;
    int unused_mode;
    press_for_act("busy_hold", 0);
    // poke mid act, then keep the switch up over the end of the act
    run_trace("busy_hold", 0, 5, 1'b1, next_mode);
    run_trace("held_restart", next_mode, -1, 1'b0, unused_mode);
    repeat (4) begin
        tick();
        check_idle("held_restart");
    end
endtask

`endif

// File: tb/tb_useless_box.sv
module tb_useless_box;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;

    // act lengths in cycles, sums of the phase durations
    localparam int PLAIN_LEN  = 18;
    localparam int SLOW_LEN   = 38;
    localparam int PEEK_LEN   = 36;
    localparam int REPEAT_LEN = 54;

    // the busy test runs a plain act and then at worst a repeat act
    localparam int ACT_CYCLES = PLAIN_LEN + SLOW_LEN + PEEK_LEN + REPEAT_LEN
                                + PLAIN_LEN + REPEAT_LEN;
    localparam int MARGIN_CYCLES   = 6 * 8 + RST_CYCLES + 20;
    localparam int WATCHDOG_CYCLES = (ACT_CYCLES * 3) / 2 + MARGIN_CYCLES;

    logic                clk;
    logic                rst;
    logic                switch_in;
    box_pkg::motor_cmd_t motor;
    box_pkg::phase_e     phase;
    box_pkg::mode_t      mode;
    logic                busy;

    int             cycle_cnt;  // tracks the DUT mode counter
    int             err_phase;
    int             err_busy;
    int             err_mode;
    int             err_motor;
    box_pkg::mode_t last_mode;  // act shown on the mode output while idle

    useless_box_top UUT (
        .clk       (clk),
        .rst       (rst),
        .switch_in (switch_in),
        .motor     (motor),
        .phase     (phase),
        .mode      (mode),
        .busy      (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    `include "tb_tests.svh"

    initial begin
        int total_err;
        clk       = 1'b0;
        rst       = 1'b1;
        switch_in = 1'b0;
        err_phase = 0;
        err_busy  = 0;
        err_mode  = 0;
        err_motor = 0;
        last_mode = '0;

        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;

        check_reset_state();
        play_plain_act();
        play_slow_act();
        play_peek_act();
        play_repeat_act();
        check_busy_and_hold();

        total_err = err_phase + err_busy + err_mode + err_motor;
        $display("errors: phase %0d, busy %0d, mode %0d, motor %0d, total %0d",
                 err_phase, err_busy, err_mode, err_motor, total_err);
        if (total_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: design/useless_box_top.sv
module useless_box_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                switch_in,
    output box_pkg::motor_cmd_t motor,
    output box_pkg::phase_e     phase,
    output box_pkg::mode_t      mode,
    output logic                busy
);

    box_pkg::start_req_t req;
    box_pkg::phase_evt_t evt;

    // switch sampling and act choice
    mode_picker u_mode_picker (
        .clk       (clk),
        .rst       (rst),
        .switch_in (switch_in),
        .req       (req)
    );

    // act state machine
    phase_sequencer u_phase_sequencer (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .evt  (evt),
        .mode (mode),
        .busy (busy)
    );

    // lid and hand motor pulses
    motor_driver u_motor_driver (
        .clk   (clk),
        .rst   (rst),
        .evt   (evt),
        .motor (motor)
    );

    assign phase = evt.phase;

endmodule

// File: design/motor_driver.sv
`include "box_params.svh"

module motor_driver (
    input  logic                clk,
    input  logic                rst,
    input  box_pkg::phase_evt_t evt,
    output box_pkg::motor_cmd_t motor
);

    box_pkg::motor_cmd_t cmd;
    box_pkg::pulse_cnt_t pulse_len;
    logic                expired;

    // which motor moves, and which way, for the phase just entered
    always_comb begin
        cmd       = '0;
        pulse_len = box_pkg::pulse_cnt_t'(`BOX_LID_PULSE);
        case (evt.phase)
            box_pkg::OPEN_LID: begin
                cmd.lid_en  = 1'b1;
                cmd.lid_dir = box_pkg::DIR_OPEN;
            end
            box_pkg::CLOSE_LID: begin
                cmd.lid_en  = 1'b1;
                cmd.lid_dir = box_pkg::DIR_CLOSE;
            end
            box_pkg::HAND_OUT: begin
                cmd.hand_en  = 1'b1;
                cmd.hand_dir = box_pkg::DIR_OUT;
                pulse_len    = box_pkg::pulse_cnt_t'(`BOX_HAND_PULSE);
            end
            box_pkg::HAND_IN: begin
                cmd.hand_en  = 1'b1;
                cmd.hand_dir = box_pkg::DIR_IN;
                pulse_len    = box_pkg::pulse_cnt_t'(`BOX_HAND_PULSE);
            end
            default: cmd = '0;
        endcase
    end

    interval_timer #(
        .count_t (box_pkg::pulse_cnt_t)
    ) u_pulse_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (evt.enter),
        .length  (pulse_len),
        .expired (expired)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            motor <= '0;
        end else if (evt.enter) begin
            motor <= cmd;          // a new phase overrides any tail of the last pulse
        end else if (expired) begin
            motor <= '0;           // enable and direction drop together
        end
    end

endmodule

// File: design/phase_sequencer.sv
`include "box_params.svh"

module phase_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  box_pkg::start_req_t req,
    output box_pkg::phase_evt_t evt,
    output box_pkg::mode_t      mode,
    output logic                busy
);

    localparam int PEEK_W = $clog2(`BOX_PEEK_COUNT + 1);
    localparam int REP_W  = $clog2(`BOX_HAND_REPEAT + 1);

    localparam logic [PEEK_W-1:0] PEEK_LAST = PEEK_W'(`BOX_PEEK_COUNT);
    localparam logic [REP_W-1:0]  REP_LAST  = REP_W'(`BOX_HAND_REPEAT - 1);

    box_pkg::phase_e     phase_q;
    box_pkg::phase_e     phase_d;
    logic                enter_q;
    box_pkg::mode_t      act_q;
    box_pkg::mode_t      lut_mode;
    logic [PEEK_W-1:0]   peek_q;   // empty peeks done in act 2
    logic [REP_W-1:0]    rep_q;    // extra hand strokes done in act 3
    logic                load;
    logic                expired;
    box_pkg::phase_cnt_t dur;

    function automatic box_pkg::phase_cnt_t phase_len(box_pkg::phase_e ph,
                                                      box_pkg::mode_t m);
        logic                slow;
        box_pkg::phase_cnt_t len;
        slow = (m == box_pkg::MODE_SLOW);
        case (ph)
            box_pkg::OPEN_LID: begin
                len = slow ? box_pkg::phase_cnt_t'(`BOX_LID_OPEN_SLOW)
                           : box_pkg::phase_cnt_t'(`BOX_LID_OPEN_FAST);
            end
            box_pkg::HAND_OUT, box_pkg::HAND_IN: begin
                len = slow ? box_pkg::phase_cnt_t'(`BOX_HAND_SLOW)
                           : box_pkg::phase_cnt_t'(`BOX_HAND_FAST);
            end
            box_pkg::CLOSE_LID: len = box_pkg::phase_cnt_t'(`BOX_LID_CLOSE);
            default:            len = '0;
        endcase
        return len;
    endfunction

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            box_pkg::IDLE: begin
                if (req.go) phase_d = box_pkg::OPEN_LID;  // go while busy is dropped
            end
            box_pkg::OPEN_LID: begin
                if (expired) begin
                    if (act_q == box_pkg::MODE_PEEK && peek_q != PEEK_LAST) begin
                        phase_d = box_pkg::CLOSE_LID;
                    end else begin
                        phase_d = box_pkg::HAND_OUT;
                    end
                end
            end
            box_pkg::HAND_OUT: begin
                if (expired) phase_d = box_pkg::HAND_IN;
            end
            box_pkg::HAND_IN: begin
                if (expired) begin
                    if (act_q == box_pkg::MODE_REPEAT && rep_q != REP_LAST) begin
                        phase_d = box_pkg::HAND_OUT;
                    end else begin
                        phase_d = box_pkg::CLOSE_LID;
                    end
                end
            end
            box_pkg::CLOSE_LID: begin
                if (expired) begin
                    if (act_q == box_pkg::MODE_PEEK && peek_q != PEEK_LAST) begin
                        phase_d = box_pkg::OPEN_LID;
                    end else begin
                        phase_d = box_pkg::IDLE;
                    end
                end
            end
            default: phase_d = box_pkg::IDLE;
        endcase
    end

    // the new act is not latched yet on the way out of IDLE
    assign lut_mode = (phase_q == box_pkg::IDLE) ? req.mode : act_q;
    assign load     = (phase_d != phase_q) && (phase_d != box_pkg::IDLE);
    assign dur      = phase_len(phase_d, lut_mode);

    interval_timer #(
        .count_t (box_pkg::phase_cnt_t)
    ) u_phase_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .length  (dur),
        .expired (expired)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= box_pkg::IDLE;
            enter_q <= 1'b0;
            act_q   <= '0;
            peek_q  <= '0;
            rep_q   <= '0;
        end else begin
            phase_q <= phase_d;
            enter_q <= load;
            if (phase_q == box_pkg::IDLE && req.go) begin
                act_q  <= req.mode;
                peek_q <= '0;
                rep_q  <= '0;
            end else begin
                if (phase_q == box_pkg::CLOSE_LID && phase_d == box_pkg::OPEN_LID) begin
                    peek_q <= peek_q + PEEK_W'(1);
                end
                if (phase_q == box_pkg::HAND_IN && phase_d == box_pkg::HAND_OUT) begin
                    rep_q <= rep_q + REP_W'(1);
                end
            end
        end
    end

    assign evt  = '{phase: phase_q, enter: enter_q};
    assign mode = act_q;
    assign busy = (phase_q != box_pkg::IDLE);

endmodule

// File: design/mode_picker.sv
module mode_picker (
    input  logic                clk,
    input  logic                rst,
    input  logic                switch_in,
    output box_pkg::start_req_t req
);

    // free running, so the act depends on when the switch gets flipped
    box_pkg::mode_t mode_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_cnt <= '0;
        end else begin
            mode_cnt <= mode_cnt + box_pkg::mode_t'(1);
        end
    end

    // switch level sampled together with the counter value
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= '0;
        end else begin
            req.go   <= switch_in;
            req.mode <= mode_cnt;
        end
    end

endmodule

// File: design/interval_timer.sv
module interval_timer #(
    parameter type count_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   load,
    input  count_t length,
    output logic   expired
);

    count_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= length;
        end else if (count != '0) begin
            count <= count - count_t'(1);
        end
    end

    // last cycle of the interval, count hits zero on the next edge
    assign expired = (count == count_t'(1));

endmodule

// File: design/box_pkg.sv
`include "box_params.svh"

package box_pkg;

    // act number: 0 plain, 1 slow, 2 peek, 3 repeat
    typedef logic [`BOX_MODE_W-1:0] mode_t;

    localparam mode_t MODE_SLOW   = mode_t'(1);
    localparam mode_t MODE_PEEK   = mode_t'(2);
    localparam mode_t MODE_REPEAT = mode_t'(3);

    typedef enum logic [2:0] {
        IDLE,
        OPEN_LID,
        HAND_OUT,
        HAND_IN,
        CLOSE_LID
    } phase_e;

    typedef logic [`BOX_PHASE_CNT_W-1:0] phase_cnt_t;
    typedef logic [`BOX_PULSE_CNT_W-1:0] pulse_cnt_t;

    // motor direction encodings
    localparam logic DIR_OPEN  = 1'b0;
    localparam logic DIR_CLOSE = 1'b1;
    localparam logic DIR_OUT   = 1'b0;
    localparam logic DIR_IN    = 1'b1;

    typedef struct packed {
        logic  go;
        mode_t mode;
    } start_req_t;

    typedef struct packed {
        phase_e phase;
        logic   enter;  // first cycle of a non-idle phase
    } phase_evt_t;

    typedef struct packed {
        logic lid_en;
        logic lid_dir;
        logic hand_en;
        logic hand_dir;
    } motor_cmd_t;

endpackage

// File: design/box_params.svh
`ifndef BOX_PARAMS_SVH
`define BOX_PARAMS_SVH

// widths
`define BOX_MODE_W        2
`define BOX_PHASE_CNT_W   5
`define BOX_PULSE_CNT_W   3

// motor pulse lengths in cycles
`define BOX_LID_PULSE     3
`define BOX_HAND_PULSE    6

// phase durations in cycles
`define BOX_LID_OPEN_FAST 3
`define BOX_LID_OPEN_SLOW 15   // act 1 only
`define BOX_LID_CLOSE     3    // same in every act
`define BOX_HAND_FAST     6
`define BOX_HAND_SLOW     10   // act 1 only

// act 2 peeks before the hand comes out
`define BOX_PEEK_COUNT    3

// act 3 hand strokes
`define BOX_HAND_REPEAT   4

`endif
